/* src/c16_mem_pkg.sv */
/*
 * C16 memory side: address, data and word types plus the memory slot constants
 */

`default_nettype none

package c16_mem_pkg;

	// ------------------------------------------------------------------------
	// address and data types
	// ------------------------------------------------------------------------

	// byte address into the external memory, covers ROM and TAP areas too
	typedef logic [24:0] mem_addr_t;

	// full address as presented by the CPU side
	typedef logic [15:0] cpu_addr_t;

	typedef logic [7:0] byte_t;

	// memory returns both byte lanes at once
	typedef logic [15:0] mem_word_t;

	// ------------------------------------------------------------------------
	// slot timing
	// ------------------------------------------------------------------------

	// 16 cycle slot, top counter bit selects the CPU half
	localparam int unsigned SLOT_BITS_DEFAULT = 4;

endpackage

`default_nettype wire

/* src/c16_dl_pkg.sv */
/*
 * Download bus definitions: index codes and the BASIC zero-page pointer table
 */

`default_nettype none

package c16_dl_pkg;

	// file type index sent by the host with each download
	typedef logic [7:0] dl_index_t;

	// program file, first two bytes hold the load address
	localparam dl_index_t DL_INDEX_PRG = 8'h01;

	// ------------------------------------------------------------------------
	// zero-page BASIC pointers
	// ------------------------------------------------------------------------

	localparam int unsigned NUM_ZP_PTRS = 4;

	typedef logic [15:0] zp_ptr_t;

	// low byte address of each pointer, high byte sits right above it
	localparam c16_mem_pkg::cpu_addr_t ZP_PTR_BASE [NUM_ZP_PTRS] = '{
		16'h002d,
		16'h002f,
		16'h0031,
		16'h009d
	};

endpackage

`default_nettype wire

/* src/dl_bus_if.sv */
/*
 * Byte-wide download bus from the host
 */

`timescale 1ns/1ps
`default_nettype none

interface dl_bus_if;

	logic                     download_active;
	c16_dl_pkg::dl_index_t    index;
	// one cycle strobe, addr and data valid with it
	logic                     wr;
	c16_mem_pkg::mem_addr_t   addr;
	c16_mem_pkg::byte_t       data;

	modport source (output download_active, output index, output wr,
		output addr, output data);

	modport sink (input download_active, input index, input wr,
		input addr, input data);

endinterface

`default_nettype wire

/* src/prg_injector.sv */
/*
 * PRG injector: captures the load address and writes each following byte
 * to memory during the IO half of the memory slot
 */

`timescale 1ns/1ps
`default_nettype none

module prg_injector #(
	parameter int unsigned SLOT_BITS = c16_mem_pkg::SLOT_BITS_DEFAULT
) (
	input  wire                     clk28,
	input  wire                     reset,
	dl_bus_if.sink                  dl,
	output logic                    mem_wr_o,
	output c16_mem_pkg::mem_addr_t  mem_addr_o,
	output c16_mem_pkg::byte_t      mem_data_o,
	output c16_mem_pkg::mem_addr_t  end_addr_o
);

	logic [SLOT_BITS-1:0]   slot_cnt;
	logic [SLOT_BITS-1:0]   slot_nxt;
	logic                   clkref;
	logic                   last_clkref;
	logic                   io_start;
	logic                   io_end;
	logic                   prg_wr;
	logic                   pending;
	logic                   wr_stage;
	c16_mem_pkg::byte_t     pend_data;
	c16_mem_pkg::byte_t     wr_data;
	c16_mem_pkg::mem_addr_t wr_addr;

	// ------------------------------------------------------------------------
	// slot counter
	// ------------------------------------------------------------------------

	assign slot_nxt = slot_cnt + SLOT_BITS'(1);

	// high = CPU slice, low = IO slice
	assign clkref = slot_cnt[SLOT_BITS-1];

	// first IO cycle, and last IO cycle before the CPU takes over
	assign io_start = last_clkref & ~clkref;
	assign io_end   = ~clkref & slot_nxt[SLOT_BITS-1];

	always_ff @(posedge clk28) begin
		if (reset) begin
			slot_cnt    <= '0;
			last_clkref <= 1'b0;
		end else begin
			slot_cnt    <= slot_nxt;
			last_clkref <= clkref;
		end
	end

	// ------------------------------------------------------------------------
	// download capture and write stage
	// ------------------------------------------------------------------------

	assign prg_wr = dl.wr && dl.download_active &&
		(dl.index == c16_dl_pkg::DL_INDEX_PRG);

	always_ff @(posedge clk28) begin
		if (reset) begin
			pending  <= 1'b0;
			wr_stage <= 1'b0;
			wr_addr  <= '0;
		end else begin
			// pending byte goes out for the rest of this IO slice
			if (io_start) begin
				wr_stage <= pending;
				pending  <= 1'b0;
			end

			// write done, step to the next free byte
			if (io_end && wr_stage) begin
				wr_stage <= 1'b0;
				wr_addr  <= wr_addr + c16_mem_pkg::mem_addr_t'(1);
			end

			if (prg_wr) begin
				if (dl.addr == '0)
					wr_addr[7:0] <= dl.data;
				else if (dl.addr == c16_mem_pkg::mem_addr_t'(1))
					wr_addr[24:8] <= {9'd0, dl.data};
				else
					pending <= 1'b1;
			end
		end
	end

	// data bytes only, control above decides if they are used
	always_ff @(posedge clk28) begin
		if (prg_wr)
			pend_data <= dl.data;
		if (io_start && pending)
			wr_data <= pend_data;
	end

	assign mem_wr_o   = wr_stage;
	assign mem_addr_o = wr_addr;
	assign mem_data_o = wr_data;
	assign end_addr_o = wr_addr;

endmodule

`default_nettype wire

/* src/zp_decoder.sv */
/*
 * Zero-page pointer decoder: address hits, CPU write pulse, end of download
 */

`timescale 1ns/1ps
`default_nettype none

module zp_decoder #(
	parameter int unsigned NUM_PTRS = c16_dl_pkg::NUM_ZP_PTRS
) (
	input  wire                       clk28,
	input  wire                       reset,
	dl_bus_if.sink                    dl,
	input  c16_mem_pkg::cpu_addr_t    cpu_addr_i,
	input  wire                       cpu_cas_n_i,
	input  wire                       cpu_rw_i,
	output logic [NUM_PTRS-1:0]       sel_lo_o,
	output logic [NUM_PTRS-1:0]       sel_hi_o,
	output logic                      wr_pulse_o,
	output logic                      load_o
);

	logic cas_n_d;
	logic prg_dl;
	logic prg_dl_d;

	// ------------------------------------------------------------------------
	// address decode
	// ------------------------------------------------------------------------

	for (genvar i = 0; i < NUM_PTRS; i++) begin : g_sel
		assign sel_lo_o[i] = (cpu_addr_i == c16_dl_pkg::ZP_PTR_BASE[i]);
		// high byte right above the low byte
		assign sel_hi_o[i] = (cpu_addr_i == c16_dl_pkg::ZP_PTR_BASE[i] + 16'd1);
	end

	// ------------------------------------------------------------------------
	// timing
	// ------------------------------------------------------------------------

	assign prg_dl = dl.download_active &&
		(dl.index == c16_dl_pkg::DL_INDEX_PRG);

	always_ff @(posedge clk28) begin
		if (reset) begin
			cas_n_d    <= 1'b1;
			wr_pulse_o <= 1'b0;
			prg_dl_d   <= 1'b0;
			load_o     <= 1'b0;
		end else begin
			cas_n_d <= cpu_cas_n_i;
			// one cycle after cas falls, address has settled by then
			wr_pulse_o <= !cpu_cas_n_i && cas_n_d && !cpu_rw_i;

			prg_dl_d <= prg_dl;
			// PRG download just ended
			load_o <= !prg_dl && prg_dl_d;
		end
	end

endmodule

`default_nettype wire

/* src/zp_pointer_reg.sv */
/*
 * One 16-bit zero-page shadow pointer with byte writes and a word load
 */

`timescale 1ns/1ps
`default_nettype none

module zp_pointer_reg (
	input  wire                    clk28,
	input  wire                    reset,
	input  wire                    sel_lo_i,
	input  wire                    sel_hi_i,
	input  wire                    wr_pulse_i,
	input  wire                    load_i,
	input  c16_dl_pkg::zp_ptr_t    load_val_i,
	input  c16_mem_pkg::byte_t     wr_data_i,
	output c16_dl_pkg::zp_ptr_t    ptr_o
);

	c16_dl_pkg::zp_ptr_t ptr;

	always_ff @(posedge clk28) begin
		if (reset) begin
			ptr <= '0;
		end else if (load_i) begin
			// end of injection wins over CPU writes
			ptr <= load_val_i;
		end else if (wr_pulse_i) begin
			if (sel_lo_i)
				ptr[7:0] <= wr_data_i;
			if (sel_hi_i)
				ptr[15:8] <= wr_data_i;
		end
	end

	assign ptr_o = ptr;

endmodule

`default_nettype wire

/* src/cpu_read_mux.sv */
/*
 * CPU read data: pointer overlay on a zero-page hit, else memory byte lane
 */

`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux #(
	parameter int unsigned NUM_PTRS = c16_dl_pkg::NUM_ZP_PTRS
) (
	input  c16_dl_pkg::zp_ptr_t    ptrs_i [NUM_PTRS],
	input  wire [NUM_PTRS-1:0]     sel_lo_i,
	input  wire [NUM_PTRS-1:0]     sel_hi_i,
	input  wire                    cpu_addr_lsb_i,
	input  c16_mem_pkg::mem_word_t mem_rdata_i,
	output c16_mem_pkg::byte_t     cpu_din_o
);

	logic               ovl_hit;
	c16_mem_pkg::byte_t ovl_data;

	assign ovl_hit = |{sel_lo_i, sel_hi_i};

	// at most one select is set, address decode is exclusive
	always_comb begin
		ovl_data = 8'hff;
		for (int i = 0; i < NUM_PTRS; i++) begin
			if (sel_lo_i[i])
				ovl_data = ptrs_i[i][7:0];
			if (sel_hi_i[i])
				ovl_data = ptrs_i[i][15:8];
		end
	end

	// odd address reads the upper lane
	always_comb begin
		if (ovl_hit)
			cpu_din_o = ovl_data;
		else if (cpu_addr_lsb_i)
			cpu_din_o = mem_rdata_i[15:8];
		else
			cpu_din_o = mem_rdata_i[7:0];
	end

endmodule

`default_nettype wire

/* src/c16_inject_top.sv */
/*
 * C16 PRG injection top: download injector, zero-page pointer overlay and
 * CPU read path
 */

`timescale 1ns/1ps
`default_nettype none

module c16_inject_top #(
	parameter int unsigned SLOT_BITS = c16_mem_pkg::SLOT_BITS_DEFAULT,
	parameter int unsigned NUM_PTRS  = c16_dl_pkg::NUM_ZP_PTRS
) (
	input  wire                      clk28,
	input  wire                      reset,
	// download from the host
	input  wire                      dl_active_i,
	input  c16_dl_pkg::dl_index_t    dl_index_i,
	input  wire                      dl_wr_i,
	input  c16_mem_pkg::mem_addr_t   dl_addr_i,
	input  c16_mem_pkg::byte_t       dl_data_i,
	// memory
	output logic                     mem_wr_o,
	output c16_mem_pkg::mem_addr_t   mem_addr_o,
	output c16_mem_pkg::byte_t       mem_data_o,
	input  c16_mem_pkg::mem_word_t   mem_rdata_i,
	// CPU
	input  c16_mem_pkg::cpu_addr_t   cpu_addr_i,
	input  wire                      cpu_cas_n_i,
	input  wire                      cpu_rw_i,
	input  c16_mem_pkg::byte_t       cpu_dout_i,
	output c16_mem_pkg::byte_t       cpu_din_o
);

	c16_mem_pkg::mem_addr_t end_addr;
	c16_dl_pkg::zp_ptr_t    load_val;
	c16_dl_pkg::zp_ptr_t    ptrs [NUM_PTRS];
	logic [NUM_PTRS-1:0]    sel_lo;
	logic [NUM_PTRS-1:0]    sel_hi;
	logic                   wr_pulse;
	logic                   load;

	// ------------------------------------------------------------------------
	// download bus, source side driven from the ports
	// ------------------------------------------------------------------------

	dl_bus_if dl_bus ();

	assign dl_bus.download_active = dl_active_i;
	assign dl_bus.index           = dl_index_i;
	assign dl_bus.wr              = dl_wr_i;
	assign dl_bus.addr            = dl_addr_i;
	assign dl_bus.data            = dl_data_i;

	prg_injector #(.SLOT_BITS(SLOT_BITS)) u_injector (
		.clk28      (clk28),
		.reset      (reset),
		.dl         (dl_bus.sink),
		.mem_wr_o   (mem_wr_o),
		.mem_addr_o (mem_addr_o),
		.mem_data_o (mem_data_o),
		.end_addr_o (end_addr)
	);

	// ------------------------------------------------------------------------
	// zero-page pointer overlay
	// ------------------------------------------------------------------------

	zp_decoder #(.NUM_PTRS(NUM_PTRS)) u_decoder (
		.clk28       (clk28),
		.reset       (reset),
		.dl          (dl_bus.sink),
		.cpu_addr_i  (cpu_addr_i),
		.cpu_cas_n_i (cpu_cas_n_i),
		.cpu_rw_i    (cpu_rw_i),
		.sel_lo_o    (sel_lo),
		.sel_hi_o    (sel_hi),
		.wr_pulse_o  (wr_pulse),
		.load_o      (load)
	);

	// BASIC wants the byte after the last one loaded, plus one
	assign load_val = end_addr[15:0] + 16'd1;

	for (genvar i = 0; i < NUM_PTRS; i++) begin : g_ptr
		zp_pointer_reg u_ptr (
			.clk28      (clk28),
			.reset      (reset),
			.sel_lo_i   (sel_lo[i]),
			.sel_hi_i   (sel_hi[i]),
			.wr_pulse_i (wr_pulse),
			.load_i     (load),
			.load_val_i (load_val),
			.wr_data_i  (cpu_dout_i),
			.ptr_o      (ptrs[i])
		);
	end

	cpu_read_mux #(.NUM_PTRS(NUM_PTRS)) u_read_mux (
		.ptrs_i         (ptrs),
		.sel_lo_i       (sel_lo),
		.sel_hi_i       (sel_hi),
		.cpu_addr_lsb_i (cpu_addr_i[0]),
		.mem_rdata_i    (mem_rdata_i),
		.cpu_din_o      (cpu_din_o)
	);

endmodule

`default_nettype wire

/* tb/tb_c16_inject_assertions.sv */
/*
 * Protocol assertions for the PRG injection top, bound to it from the testbench
 */

`timescale 1ns/1ps
`default_nettype none

module tb_c16_inject_assertions (
	input wire                    clk28,
	input wire                    reset,
	input wire                    mem_wr_i,
	input c16_mem_pkg::mem_addr_t mem_addr_i,
	input wire                    dl_wr_i,
	input wire                    clkref_i,
	input wire                    pending_i
);

	int unsigned fail_cnt = 0;

	// writes belong to the IO slice only
	a_no_wr_in_cpu_slice: assert property (@(posedge clk28) disable iff (reset)
		clkref_i |-> !mem_wr_i)
		else begin
			fail_cnt++;
			$error("memory write during the CPU slice");
		end

	a_addr_stable: assert property (@(posedge clk28) disable iff (reset)
		mem_wr_i && $past(mem_wr_i) |-> $stable(mem_addr_i))
		else begin
			fail_cnt++;
			$error("memory address moved during a write");
		end

	// no ready signal, source must leave room for the IO slice
	a_no_overrun: assert property (@(posedge clk28) disable iff (reset)
		dl_wr_i |-> !pending_i)
		else begin
			fail_cnt++;
			$error("download strobe while a byte is still pending");
		end

endmodule

bind c16_inject_top tb_c16_inject_assertions u_assertions (
	.clk28      (clk28),
	.reset      (reset),
	.mem_wr_i   (mem_wr_o),
	.mem_addr_i (mem_addr_o),
	.dl_wr_i    (dl_wr_i),
	.clkref_i   (u_injector.clkref),
	.pending_i  (u_injector.pending)
);

`default_nettype wire

/* tb/tb_c16_inject.sv */
/*
 * Testbench for the PRG injection top: trace driven downloads, CPU cycles and a memory model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_c16_inject;

	localparam int STROBE_GAP = 20;
	localparam int WAIT_LIMIT = 200;

	logic                   clk28;
	logic                   reset;
	logic                   dl_active;
	c16_dl_pkg::dl_index_t  dl_index;
	logic                   dl_wr;
	c16_mem_pkg::mem_addr_t dl_addr;
	c16_mem_pkg::byte_t     dl_data;
	logic                   mem_wr;
	c16_mem_pkg::mem_addr_t mem_addr;
	c16_mem_pkg::byte_t     mem_data;
	c16_mem_pkg::mem_word_t mem_rdata;
	c16_mem_pkg::cpu_addr_t cpu_addr;
	logic                   cpu_cas_n;
	logic                   cpu_rw;
	c16_mem_pkg::byte_t     cpu_dout;
	c16_mem_pkg::byte_t     cpu_din;

	// memory model, one word per even byte address
	c16_mem_pkg::mem_word_t mem [32768];
	c16_mem_pkg::mem_addr_t exp_addr_q [$];
	c16_mem_pkg::byte_t     exp_data_q [$];
	c16_mem_pkg::mem_addr_t exp_addr;
	c16_mem_pkg::byte_t     exp_data;
	logic                   wr_seen;
	integer                 seed = 15856;

	c16_inject_top UUT (
		.clk28       (clk28),
		.reset       (reset),
		.dl_active_i (dl_active),
		.dl_index_i  (dl_index),
		.dl_wr_i     (dl_wr),
		.dl_addr_i   (dl_addr),
		.dl_data_i   (dl_data),
		.mem_wr_o    (mem_wr),
		.mem_addr_o  (mem_addr),
		.mem_data_o  (mem_data),
		.mem_rdata_i (mem_rdata),
		.cpu_addr_i  (cpu_addr),
		.cpu_cas_n_i (cpu_cas_n),
		.cpu_rw_i    (cpu_rw),
		.cpu_dout_i  (cpu_dout),
		.cpu_din_o   (cpu_din)
	);

	assign mem_rdata = mem[cpu_addr[15:1]];

	initial begin
		clk28 = 1'b0;
		forever #5 clk28 = ~clk28;
	end

	// ------------------------------------------------------------------------
	// error handling and compare tasks
	// ------------------------------------------------------------------------

	task automatic stop_on_error();
		$display("Some tests failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		stop_on_error();
	endtask

	task automatic check_byte(input c16_mem_pkg::byte_t got, input c16_mem_pkg::byte_t exp,
		input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %02h expected %02h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_addr(input c16_mem_pkg::mem_addr_t got,
		input c16_mem_pkg::mem_addr_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %07h expected %07h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_ptr(input c16_dl_pkg::zp_ptr_t got, input c16_dl_pkg::zp_ptr_t exp,
		input string what);
		if (got !== exp) begin
			$display("Fail at %0t: %s got %04h expected %04h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	function automatic c16_mem_pkg::byte_t model_byte(input c16_mem_pkg::cpu_addr_t addr);
		c16_mem_pkg::mem_word_t word;
		word = mem[addr[15:1]];
		return addr[0] ? word[15:8] : word[7:0];
	endfunction

	// ------------------------------------------------------------------------
	// memory write monitor
	// ------------------------------------------------------------------------

	always @(negedge clk28) begin
		if (!reset && mem_wr) begin
			if (mem_addr[0])
				mem[mem_addr[15:1]][15:8] = mem_data;
			else
				mem[mem_addr[15:1]][7:0] = mem_data;
			// each new write must match the oldest data byte sent
			if (!wr_seen) begin
				if (exp_addr_q.size() == 0)
					report_problem("memory write with no data byte outstanding");
				exp_addr = exp_addr_q.pop_front();
				exp_data = exp_data_q.pop_front();
				check_addr(mem_addr, exp_addr, "write address");
				check_byte(mem_data, exp_data, "write data");
			end
		end
		wr_seen = mem_wr;
	end

	// ------------------------------------------------------------------------
	// bus cycles
	// ------------------------------------------------------------------------

	task automatic cpu_read(input c16_mem_pkg::cpu_addr_t addr, output c16_mem_pkg::byte_t data);
		@(posedge clk28);
		#1;
		cpu_addr  = addr;
		cpu_rw    = 1'b1;
		cpu_cas_n = 1'b0;
		@(negedge clk28);
		data = cpu_din;
		@(posedge clk28);
		#1;
		cpu_cas_n = 1'b1;
	endtask

	task automatic cpu_write(input c16_mem_pkg::cpu_addr_t addr, input c16_mem_pkg::byte_t data);
		@(posedge clk28);
		#1;
		cpu_addr  = addr;
		cpu_rw    = 1'b0;
		cpu_dout  = data;
		cpu_cas_n = 1'b0;
		// pulse on the first edge, byte lands on the second
		repeat (2) @(posedge clk28);
		#1;
		cpu_cas_n = 1'b1;
		cpu_rw    = 1'b1;
	endtask

	task automatic check_pointers(input c16_dl_pkg::zp_ptr_t exp);
		c16_mem_pkg::byte_t lo;
		c16_mem_pkg::byte_t hi;
		for (int p = 0; p < c16_dl_pkg::NUM_ZP_PTRS; p++) begin
			cpu_read(c16_dl_pkg::ZP_PTR_BASE[p], lo);
			cpu_read(c16_dl_pkg::ZP_PTR_BASE[p] + 16'd1, hi);
			check_ptr({hi, lo}, exp, "pointer after download");
		end
	endtask

	task automatic run_download(input c16_mem_pkg::cpu_addr_t load, input int count);
		c16_mem_pkg::byte_t data;
		int                 cnt;
		@(posedge clk28);
		#1;
		dl_active = 1'b1;
		dl_index  = c16_dl_pkg::DL_INDEX_PRG;
		for (int i = 0; i < count + 2; i++) begin
			if (i == 0) begin
				data = load[7:0];
			end else if (i == 1) begin
				data = load[15:8];
			end else begin
				data = c16_mem_pkg::byte_t'($random(seed));
				exp_addr_q.push_back(c16_mem_pkg::mem_addr_t'(load) +
					c16_mem_pkg::mem_addr_t'(i - 2));
				exp_data_q.push_back(data);
			end
			dl_wr   = 1'b1;
			dl_addr = c16_mem_pkg::mem_addr_t'(i);
			dl_data = data;
			@(posedge clk28);
			#1;
			dl_wr = 1'b0;
			repeat (STROBE_GAP - 1) @(posedge clk28);
			#1;
		end
		cnt = 0;
		while (exp_addr_q.size() != 0 || mem_wr) begin
			if (cnt == WAIT_LIMIT)
				report_problem("timeout waiting for memory writes to finish");
			cnt++;
			@(negedge clk28);
		end
		@(posedge clk28);
		#1;
		dl_active = 1'b0;
		repeat (4) @(posedge clk28);
		check_pointers(c16_dl_pkg::zp_ptr_t'(load + 16'(count) + 16'd1));
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		int                 fd;
		int                 n;
		logic [7:0]         cmd;
		logic [31:0]        a;
		logic [31:0]        b;
		string              line;
		c16_mem_pkg::byte_t got;
		c16_mem_pkg::byte_t exp;
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_index  = '0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_addr  = '0;
		cpu_cas_n = 1'b1;
		cpu_rw    = 1'b1;
		cpu_dout  = '0;
		wr_seen   = 1'b0;
		// fill depends on every address bit
		for (int i = 0; i < 32768; i++)
			mem[i] = c16_mem_pkg::mem_word_t'(i * 291) ^ 16'h5aa5;
		repeat (2) @(posedge clk28);
		#1;
		reset = 1'b0;

		fd = $fopen("tb/inject_trace.txt", "r");
		if (fd == 0)
			report_problem("cannot open the trace file tb/inject_trace.txt");
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, "%c %h %h", cmd, a, b);
			if (n < 2 || cmd == "#")
				continue;
			case (cmd)
				"D": run_download(c16_mem_pkg::cpu_addr_t'(a), int'(b));
				"R": begin
					cpu_read(c16_mem_pkg::cpu_addr_t'(a), got);
					if (n == 3)
						exp = c16_mem_pkg::byte_t'(b);
					else
						exp = model_byte(c16_mem_pkg::cpu_addr_t'(a));
					check_byte(got, exp, $sformatf("cpu read of %04h", a[15:0]));
				end
				"W": cpu_write(c16_mem_pkg::cpu_addr_t'(a), c16_mem_pkg::byte_t'(b));
				default: report_problem("unknown command in the trace file");
			endcase
		end
		$fclose(fd);

		repeat (4) @(posedge clk28);
		if (UUT.u_assertions.fail_cnt != 0) begin
			$display("protocol assertions failed during the run");
			stop_on_error();
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb/inject_trace.txt */
# D load count : PRG download | R addr byte : read checked against byte, - uses memory model
# W addr byte : CPU write | all values hex
R 002d 00
R 002e 00
R 0032 00
R 009e 00
R 1000 -
R 1001 -
D 1001 10
R 002d 12
R 002e 10
R 0031 12
R 0032 10
R 1001 -
R 1010 -
R 1011 -
W 002f 55
R 002f 55
R 0030 10
R 002d 12
D 3ffe 05
R 009d 04
R 009e 40
R 3ffe -
R 3fff -
W 009e a7
R 009e a7
R 009d 04

/* build.f */
src/c16_mem_pkg.sv
src/c16_dl_pkg.sv
src/dl_bus_if.sv
src/prg_injector.sv
src/zp_decoder.sv
src/zp_pointer_reg.sv
src/cpu_read_mux.sv
src/c16_inject_top.sv
tb/tb_c16_inject_assertions.sv
tb/tb_c16_inject.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_c16_inject
FILELIST := build.f
LOG      := sim.log
FAIL_MSG := Some tests failed
PASS_MSG := All tests passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
